// ==== project.f ====
+incdir+src
src/neuron_pkg.sv
src/synapse_table.sv
src/membrane_if.sv
src/spike_stretcher.sv
src/neuron_top.sv
testbench/tb_clock.sv
testbench/neuron_asserts.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// ==== src/membrane_if.sv ====
// Integrate-and-fire membrane
// Holds the writable bias current and the membrane potential v
// Spike decision is combinational during the evaluate cycle

`timescale 1ns/10ps
`default_nettype none

`include "neuron_consts.svh"

module membrane_if (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       nc_reset,
    input  logic                       nc_evaluate,
    input  logic                       mem_we,
    input  logic [`NEUR_ADDR_BW-1:0]   mem_addr,
    input  logic [`NEUR_DATA_BW-1:0]   mem_data,
    input  neuron_pkg::current_t       syn_current,
    output logic                       spiking,
    output neuron_pkg::membrane_t      v_out
);

    neuron_pkg::current_t  ccur;
    neuron_pkg::current_t  total_cur;
    neuron_pkg::membrane_t v;
    neuron_pkg::membrane_t v_nxt;

    // One bit of headroom over v for the update
    logic signed [`NEUR_CURRENT_BW+`NEUR_V_FRAC:0] drive;
    logic signed [`NEUR_CURRENT_BW+`NEUR_V_FRAC:0] delta;
    logic signed [`NEUR_V_FRAC+6:0]               leak;
    logic signed [`NEUR_V_BW:0]                   cand_raw;
    logic signed [`NEUR_V_BW:0]                   cand;
    logic signed [`NEUR_V_BW:0]                   v_floor;

    // Bias current register
    always_ff @(posedge clk) begin
        if (rst)
            ccur <= '0;
        else if (mem_we && mem_addr == `NEUR_ADDR_BW'(`NEUR_ADDR_CCUR))
            ccur <= neuron_pkg::current_t'(mem_data[`NEUR_CURRENT_BW-1:0]);
    end

    // --------------------
    // Membrane update
    // --------------------
    assign total_cur = ccur + syn_current;

    // Current aligned to v precision minus the constant bias
    assign drive = ($bits(drive)'(total_cur) <<< (`NEUR_V_FRAC - `NEUR_WEIGHT_FRAC))
                   - $bits(drive)'(`NEUR_LEAK_BIAS <<< `NEUR_V_FRAC);

    // Roughly 0.148 * v
    assign leak  = $bits(leak)'((v >>> 3) + (v >>> 6) + (v >>> 7));
    assign delta = drive - $bits(delta)'(leak);

    // Step of one quarter
    assign cand_raw = $bits(cand_raw)'(v) + (delta >>> 2);
    assign v_floor  = $bits(v_floor)'(`NEUR_V_FLOOR <<< `NEUR_V_FRAC);
    assign cand     = (cand_raw < v_floor) ? v_floor : cand_raw;

    // Whole part above threshold while evaluating
    assign spiking = nc_evaluate && ((cand >>> `NEUR_V_FRAC) > `NEUR_V_SPIKE);
    assign v_nxt   = spiking ? neuron_pkg::membrane_t'(`NEUR_V_AFTER <<< `NEUR_V_FRAC)
                             : neuron_pkg::membrane_t'(cand[`NEUR_V_BW-1:0]);

    always_ff @(posedge clk) begin
        if (rst || nc_reset)
            v <= neuron_pkg::membrane_t'(`NEUR_V_RST <<< `NEUR_V_FRAC);
        else if (nc_evaluate)
            v <= v_nxt;
    end

    assign v_out = v;

endmodule

`default_nettype wire

// ==== src/neuron_consts.svh ====
// Spiking neuron constants
// Widths, fixed-point precision, integrate-and-fire thresholds
// and the fixed memory map of the programmable registers

`ifndef NEURON_CONSTS_SVH
`define NEURON_CONSTS_SVH

// Weight table and datapath widths
`define NEUR_TABLE_ROWS  8
`define NEUR_IDX_BW      8
`define NEUR_WEIGHT_BW   7
`define NEUR_WEIGHT_FRAC 2
`define NEUR_CURRENT_BW  9
`define NEUR_V_FRAC      10
`define NEUR_V_BW        (`NEUR_V_FRAC + 9)
`define NEUR_CNTR_BW     6
`define NEUR_CNTR_RST    40

// Memory write port
`define NEUR_ADDR_BW     5
`define NEUR_DATA_BW     18
`define NEUR_ADDR_CCUR   0
`define NEUR_ADDR_STEP   1
// Table region, even offset = index, odd offset = weight
`define NEUR_ADDR_TABLE  2

// Integrate-and-fire model, whole units
`define NEUR_V_RST       (-70)
`define NEUR_V_SPIKE     30
`define NEUR_V_AFTER     (-65)
`define NEUR_V_FLOOR     (-256)
`define NEUR_LEAK_BIAS   8

`endif

// ==== src/neuron_pkg.sv ====
// Neuron shared types
// Signed fixed-point words used between the neuron blocks

`default_nettype none

`include "neuron_consts.svh"

package neuron_pkg;

    // Synaptic and bias current, WEIGHT_FRAC fraction bits
    typedef logic signed [`NEUR_CURRENT_BW-1:0] current_t;

    // Table weight, same fraction as the current
    typedef logic signed [`NEUR_WEIGHT_BW-1:0] weight_t;

    // Membrane potential v, V_FRAC fraction bits
    typedef logic signed [`NEUR_V_BW-1:0] membrane_t;

endpackage

`default_nettype wire

// ==== src/neuron_top.sv ====
// Spiking neuron, one hidden-layer integrate-and-fire unit
// Synaptic input, membrane model and output lengthening

`timescale 1ns/10ps
`default_nettype none

`include "neuron_consts.svh"

module neuron_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       nc_evaluate,
    input  logic                       nc_reset,
    input  logic                       nc_warmup,
    input  logic                       spike_in_valid,
    input  logic [`NEUR_IDX_BW-1:0]    spike_in_index,
    input  logic                       spike_ready,
    input  logic                       mem_we,
    input  logic [`NEUR_ADDR_BW-1:0]   mem_addr,
    input  logic [`NEUR_DATA_BW-1:0]   mem_data,
    output logic                       neur_output,
    output logic                       spike_valid,
    output neuron_pkg::membrane_t      v_out
);

    // Synaptic current into the membrane
    neuron_pkg::current_t syn_current;

    synapse_table u_synapse_table (
        .clk            (clk),
        .rst            (rst),
        .nc_reset       (nc_reset),
        .spike_in_valid (spike_in_valid),
        .spike_in_index (spike_in_index),
        .mem_we         (mem_we),
        .mem_addr       (mem_addr),
        .mem_data       (mem_data),
        .syn_current    (syn_current)
    );

    // Spike decision feeds the stretcher and the output evaluator
    membrane_if u_membrane_if (
        .clk         (clk),
        .rst         (rst),
        .nc_reset    (nc_reset),
        .nc_evaluate (nc_evaluate),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_data    (mem_data),
        .syn_current (syn_current),
        .spiking     (neur_output),
        .v_out       (v_out)
    );

    spike_stretcher u_spike_stretcher (
        .clk         (clk),
        .rst         (rst),
        .nc_reset    (nc_reset),
        .nc_evaluate (nc_evaluate),
        .nc_warmup   (nc_warmup),
        .spiking     (neur_output),
        .spike_ready (spike_ready),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_data    (mem_data),
        .spike_valid (spike_valid)
    );

endmodule

`default_nettype wire

// ==== src/spike_stretcher.sv ====
// Output spike lengthening
// Writable step length, step counter and output level
// Announces a high level once per evaluation until granted

`timescale 1ns/10ps
`default_nettype none

`include "neuron_consts.svh"

module spike_stretcher (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       nc_reset,
    input  logic                       nc_evaluate,
    input  logic                       nc_warmup,
    input  logic                       spiking,
    input  logic                       spike_ready,
    input  logic                       mem_we,
    input  logic [`NEUR_ADDR_BW-1:0]   mem_addr,
    input  logic [`NEUR_DATA_BW-1:0]   mem_data,
    output logic                       spike_valid
);

    logic [`NEUR_CNTR_BW-1:0] step_len;
    logic [`NEUR_CNTR_BW-1:0] step_cntr;
    logic [`NEUR_CNTR_BW-1:0] cntr_nxt;
    logic                     level;
    logic                     level_nxt;
    logic                     announce;

    // Step length register
    always_ff @(posedge clk) begin
        if (rst)
            step_len <= `NEUR_CNTR_BW'(`NEUR_CNTR_RST);
        else if (mem_we && mem_addr == `NEUR_ADDR_BW'(`NEUR_ADDR_STEP))
            step_len <= mem_data[`NEUR_CNTR_BW-1:0];
    end

    // --------------------
    // Counter and level
    // --------------------
    // Reload on spike, otherwise count down to zero
    always_comb begin
        cntr_nxt = step_cntr;
        if (spiking)
            cntr_nxt = step_len;
        else if (|step_cntr)
            cntr_nxt = step_cntr - `NEUR_CNTR_BW'(1);
    end

    // Set on a fresh spike or on the last count
    // A spike during a running count only holds the level
    assign level_nxt = (spiking && ~|step_cntr)
                       || (!spiking && step_cntr == `NEUR_CNTR_BW'(1))
                       || (!spike_ready && level);

    always_ff @(posedge clk) begin
        if (rst || nc_reset) begin
            level     <= 1'b0;
            step_cntr <= '0;
        end else if ((nc_evaluate && !nc_warmup) || spike_ready) begin
            level     <= level_nxt;
            step_cntr <= cntr_nxt;
        end
    end

    // Announcement flag
    // Grant clears ahead of evaluate
    always_ff @(posedge clk) begin
        if (rst || spike_ready)
            announce <= 1'b0;
        else if (nc_evaluate)
            announce <= 1'b1;
    end

    assign spike_valid = level & announce;

endmodule

`default_nettype wire

// ==== src/synapse_table.sv ====
// Synaptic input block
// Addressable weight table with per-row sign bits
// Registers the incoming spike index, matches it against all rows
// and accumulates the matching weights into the synaptic current

`timescale 1ns/10ps
`default_nettype none

`include "neuron_consts.svh"

module synapse_table (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       nc_reset,
    input  logic                       spike_in_valid,
    input  logic [`NEUR_IDX_BW-1:0]    spike_in_index,
    input  logic                       mem_we,
    input  logic [`NEUR_ADDR_BW-1:0]   mem_addr,
    input  logic [`NEUR_DATA_BW-1:0]   mem_data,
    output neuron_pkg::current_t       syn_current
);

    // Table rows
    logic [`NEUR_IDX_BW-1:0] table_i [`NEUR_TABLE_ROWS];
    neuron_pkg::weight_t     table_w [`NEUR_TABLE_ROWS];
    logic [`NEUR_TABLE_ROWS-1:0] table_s;

    // Registered spike input
    logic [`NEUR_IDX_BW-1:0] idx_d;
    logic                    vld_d;

    logic [`NEUR_TABLE_ROWS-1:0] row_match;
    neuron_pkg::current_t        cur_nxt;

    // Table write decode
    logic [`NEUR_ADDR_BW-1:0]            tbl_off;
    logic                                tbl_we;
    logic [$clog2(`NEUR_TABLE_ROWS)-1:0] wr_row;

    // --------------------
    // Memory writes
    // --------------------
    assign tbl_off = mem_addr - `NEUR_ADDR_BW'(`NEUR_ADDR_TABLE);
    assign tbl_we  = mem_we && (mem_addr >= `NEUR_ADDR_BW'(`NEUR_ADDR_TABLE))
                     && (tbl_off < `NEUR_ADDR_BW'(2 * `NEUR_TABLE_ROWS));
    // Two addresses per row
    assign wr_row  = tbl_off[$clog2(`NEUR_TABLE_ROWS):1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `NEUR_TABLE_ROWS; r++) begin
                table_i[r] <= '0;
                table_w[r] <= '0;
            end
        end else if (tbl_we) begin
            if (!tbl_off[0])
                table_i[wr_row] <= mem_data[`NEUR_IDX_BW-1:0];
            else
                table_w[wr_row] <= neuron_pkg::weight_t'(mem_data[`NEUR_WEIGHT_BW-1:0]);
        end
    end

    // --------------------
    // Spike input and current
    // --------------------
    // One comparator per row, against the flopped index only
    always_comb begin
        for (int r = 0; r < `NEUR_TABLE_ROWS; r++)
            row_match[r] = vld_d && (idx_d == table_i[r]);
    end

    // Sign bit clear adds, set subtracts
    always_comb begin
        cur_nxt = syn_current;
        for (int r = 0; r < `NEUR_TABLE_ROWS; r++) begin
            if (row_match[r]) begin
                if (!table_s[r])
                    cur_nxt = cur_nxt + neuron_pkg::current_t'(table_w[r]);
                else
                    cur_nxt = cur_nxt - neuron_pkg::current_t'(table_w[r]);
            end
        end
    end

    // Table contents survive nc_reset
    always_ff @(posedge clk) begin
        if (rst || nc_reset) begin
            idx_d       <= '0;
            vld_d       <= 1'b0;
            table_s     <= '0;
            syn_current <= '0;
        end else begin
            vld_d <= spike_in_valid;
            if (spike_in_valid)
                idx_d <= spike_in_index;
            // Current moves only on a registered spike
            if (vld_d) begin
                syn_current <= cur_nxt;
                table_s     <= table_s ^ row_match;
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/neuron_asserts.sv ====
// Neuron protocol assertions
// Bound into the top level
// Checks the output handshake and that a new announcement
// only follows an evaluate cycle

`timescale 1ns/10ps
`default_nettype none

module neuron_asserts (
    input logic clk,
    input logic rst,
    input logic nc_reset,
    input logic nc_evaluate,
    input logic spike_valid,
    input logic spike_ready
);

    // Read by the testbench top for the closing line
    int fail_count = 0;

    // Pending announcement holds until granted
    a_hold: assert property (@(posedge clk)
        (!rst && !nc_reset && spike_valid && !spike_ready) |=> spike_valid)
        else begin
            $error("spike_valid dropped without spike_ready");
            fail_count++;
        end

    // Grant removes the announcement on the next cycle
    a_fall: assert property (@(posedge clk)
        (spike_valid && spike_ready) |=> !spike_valid)
        else begin
            $error("spike_valid still high one cycle after spike_ready");
            fail_count++;
        end

    // A new announcement comes from an evaluate edge
    a_eval: assert property (@(posedge clk) disable iff (rst)
        $rose(spike_valid) |-> $past(nc_evaluate))
        else begin
            $error("spike_valid rose without a preceding evaluate cycle");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== testbench/tb_checker.sv ====
// Neuron checker
// Integer model of the weight table, membrane and stretcher,
// updated on rising edges and compared with the DUT on falling edges

`timescale 1ns/10ps
`default_nettype none

`include "neuron_consts.svh"

module tb_checker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     nc_evaluate,
    input  logic                     nc_reset,
    input  logic                     nc_warmup,
    input  logic                     spike_in_valid,
    input  logic [`NEUR_IDX_BW-1:0]  spike_in_index,
    input  logic                     spike_ready,
    input  logic                     mem_we,
    input  logic [`NEUR_ADDR_BW-1:0] mem_addr,
    input  logic [`NEUR_DATA_BW-1:0] mem_data,
    input  logic                     neur_output,
    input  logic                     spike_valid,
    input  neuron_pkg::membrane_t    v_out,
    output int                       err_v,
    output int                       err_spk,
    output int                       err_vld
);

    // One whole unit of v
    localparam int VS = 1 << `NEUR_V_FRAC;

    int tbl_i [`NEUR_TABLE_ROWS];
    int tbl_w [`NEUR_TABLE_ROWS];
    bit tbl_s [`NEUR_TABLE_ROWS];
    int bias, syn, idx_q, v, step, cntr, off;
    bit vld_q, level, ann, spk, spk_q, lvl_nxt;

    // Two's complement value of the low bits
    function automatic int wrap(input int val, input int bits);
        int m;
        m = val & ((1 << bits) - 1);
        if (m >= (1 << (bits - 1)))
            m = m - (1 << bits);
        return m;
    endfunction

    // Integrate-and-fire step with the floor clamp
    function automatic int candidate(input int v_in, input int total);
        int drive;
        int leak;
        int c;
        drive = total * (1 << (`NEUR_V_FRAC - `NEUR_WEIGHT_FRAC)) - `NEUR_LEAK_BIAS * VS;
        leak  = (v_in >>> 3) + (v_in >>> 6) + (v_in >>> 7);
        c     = v_in + ((drive - leak) >>> 2);
        if (c < `NEUR_V_FLOOR * VS)
            c = `NEUR_V_FLOOR * VS;
        return c;
    endfunction

    function automatic bit fires();
        return nc_evaluate && ((candidate(v, wrap(bias + syn, `NEUR_CURRENT_BW))
                                >>> `NEUR_V_FRAC) > `NEUR_V_SPIKE);
    endfunction

    initial begin
        err_v   = 0;
        err_spk = 0;
        err_vld = 0;
    end

    // --------------------
    // Model update
    // --------------------
    always @(posedge clk) begin
        spk   = fires();
        spk_q = spk && !rst && !nc_reset;
        if (rst || nc_reset)
            v = `NEUR_V_RST * VS;
        else if (nc_evaluate)
            v = spk ? `NEUR_V_AFTER * VS : candidate(v, wrap(bias + syn, `NEUR_CURRENT_BW));
        // Stretcher, level looks at the old counter
        if (rst || nc_reset) begin
            level = 1'b0;
            cntr  = 0;
        end else if ((nc_evaluate && !nc_warmup) || spike_ready) begin
            lvl_nxt = (spk && cntr == 0) || (!spk && cntr == 1) || (!spike_ready && level);
            if (spk)
                cntr = step;
            else if (cntr != 0)
                cntr = cntr - 1;
            level = lvl_nxt;
        end
        if (rst || spike_ready)
            ann = 1'b0;
        else if (nc_evaluate)
            ann = 1'b1;
        // Alternating add and subtract per matching row
        if (rst || nc_reset) begin
            vld_q = 1'b0;
            idx_q = 0;
            syn   = 0;
            foreach (tbl_s[r])
                tbl_s[r] = 1'b0;
        end else begin
            if (vld_q) begin
                foreach (tbl_i[r]) begin
                    if (tbl_i[r] == idx_q) begin
                        syn      = tbl_s[r] ? syn - tbl_w[r] : syn + tbl_w[r];
                        tbl_s[r] = !tbl_s[r];
                    end
                end
                syn = wrap(syn, `NEUR_CURRENT_BW);
            end
            vld_q = spike_in_valid;
            if (spike_in_valid)
                idx_q = int'(spike_in_index);
        end
        // Memory map mirror
        off = int'(mem_addr) - `NEUR_ADDR_TABLE;
        if (rst) begin
            bias = 0;
            step = `NEUR_CNTR_RST;
            foreach (tbl_i[r]) begin
                tbl_i[r] = 0;
                tbl_w[r] = 0;
            end
        end else if (mem_we) begin
            if (int'(mem_addr) == `NEUR_ADDR_CCUR)
                bias = wrap(int'(mem_data), `NEUR_CURRENT_BW);
            else if (int'(mem_addr) == `NEUR_ADDR_STEP)
                step = int'(mem_data) & ((1 << `NEUR_CNTR_BW) - 1);
            else if (off >= 0 && off < 2 * `NEUR_TABLE_ROWS) begin
                if (off % 2 == 0)
                    tbl_i[off / 2] = int'(mem_data) & ((1 << `NEUR_IDX_BW) - 1);
                else
                    tbl_w[off / 2] = wrap(int'(mem_data), `NEUR_WEIGHT_BW);
            end
        end
    end

    // --------------------
    // Comparisons
    // --------------------
    always @(negedge clk) begin
        if (!rst) begin
            if (v_out !== neuron_pkg::membrane_t'(v)) begin
                err_v++;
                $display("ERR %0t: v_out %0d, expected %0d", $time, v_out, v);
            end
            if (spk_q && v_out !== neuron_pkg::membrane_t'(`NEUR_V_AFTER * VS)) begin
                err_v++;
                $display("ERR %0t: v_out %0d after a spike, not the after-spike value",
                         $time, v_out);
            end
            if (neur_output !== fires()) begin
                err_spk++;
                $display("ERR %0t: neur_output %b, expected %b", $time, neur_output, fires());
            end
            if (spike_valid !== (level && ann)) begin
                err_vld++;
                $display("ERR %0t: spike_valid %b, expected %b", $time, spike_valid,
                         level && ann);
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
// Testbench clock and reset
// 4 ns clock, reset held high for the first 16 rising edges

`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Released on a rising edge like every other stimulus
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_top.sv ====
// Spiking neuron testbench
// Programs the table, bias and step length, then runs seeded random
// rounds of input spikes and evaluations against the checker

`timescale 1ns/10ps
`default_nettype none

`include "neuron_consts.svh"

module tb_top;

    localparam int ROUNDS     = 300;
    // Longest round is well under 20 cycles
    localparam int TIMEOUT_NS = ROUNDS * 20 * 4 + 2000;

    logic clk, rst;
    logic nc_evaluate, nc_reset, nc_warmup;
    logic spike_in_valid, spike_ready, mem_we;
    logic [`NEUR_IDX_BW-1:0]  spike_in_index;
    logic [`NEUR_ADDR_BW-1:0] mem_addr;
    logic [`NEUR_DATA_BW-1:0] mem_data;
    logic neur_output, spike_valid;
    neuron_pkg::membrane_t v_out;
    int err_v, err_spk, err_vld;
    // Indices shared by the table and the input spikes
    logic [`NEUR_IDX_BW-1:0] idx_pool [16];

    tb_clock u_clock (.clk(clk), .rst(rst));

    neuron_top dut (
        .clk(clk), .rst(rst), .nc_evaluate(nc_evaluate), .nc_reset(nc_reset),
        .nc_warmup(nc_warmup), .spike_in_valid(spike_in_valid),
        .spike_in_index(spike_in_index), .spike_ready(spike_ready), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_data(mem_data), .neur_output(neur_output),
        .spike_valid(spike_valid), .v_out(v_out)
    );

    tb_checker u_checker (
        .clk(clk), .rst(rst), .nc_evaluate(nc_evaluate), .nc_reset(nc_reset),
        .nc_warmup(nc_warmup), .spike_in_valid(spike_in_valid),
        .spike_in_index(spike_in_index), .spike_ready(spike_ready), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_data(mem_data), .neur_output(neur_output),
        .spike_valid(spike_valid), .v_out(v_out), .err_v(err_v), .err_spk(err_spk),
        .err_vld(err_vld)
    );

    bind neuron_top neuron_asserts u_neuron_asserts (
        .clk(clk), .rst(rst), .nc_reset(nc_reset), .nc_evaluate(nc_evaluate),
        .spike_valid(spike_valid), .spike_ready(spike_ready)
    );

    task automatic write_reg(input int addr, input int data);
        @(posedge clk);
        mem_we      <= 1'b1;
        mem_addr    <= `NEUR_ADDR_BW'(addr);
        mem_data    <= `NEUR_DATA_BW'(data);
        spike_ready <= ($urandom % 3) == 0;
    endtask

    // One cycle of spike input and control, memory port idle
    // Arbiter grant is random on every cycle
    task automatic drive_cycle(input logic vld, input logic eval, input logic nrst);
        @(posedge clk);
        mem_we         <= 1'b0;
        spike_in_valid <= vld;
        spike_in_index <= idx_pool[$urandom % 16];
        nc_evaluate    <= eval;
        nc_reset       <= nrst;
        spike_ready    <= ($urandom % 3) == 0;
    endtask

    initial begin
        int seed;
        int n;
        int gap;
        int total;
        seed = $urandom(46);
        nc_evaluate    = 1'b0;
        nc_reset       = 1'b0;
        nc_warmup      = 1'b1;
        spike_in_valid = 1'b0;
        spike_in_index = '0;
        spike_ready    = 1'b0;
        mem_we         = 1'b0;
        mem_addr       = '0;
        mem_data       = '0;
        for (int k = 0; k < 16; k++)
            idx_pool[k] = `NEUR_IDX_BW'($urandom);
        while (rst)
            @(posedge clk);
        // --------------------
        // Table, bias and step length
        // --------------------
        for (int r = 0; r < `NEUR_TABLE_ROWS; r++) begin
            write_reg(`NEUR_ADDR_TABLE + 2 * r, idx_pool[$urandom % 16]);
            write_reg(`NEUR_ADDR_TABLE + 2 * r + 1, $urandom % 128);
        end
        // Bias near the firing point so both outcomes occur
        write_reg(`NEUR_ADDR_CCUR, 40 + $urandom % 48);
        write_reg(`NEUR_ADDR_STEP, 3 + $urandom % 10);
        // --------------------
        // Rounds
        // --------------------
        for (int rnd = 0; rnd < ROUNDS; rnd++) begin
            n   = 1 + $urandom % 4;
            gap = 2 + $urandom % 2;
            repeat (n)
                drive_cycle(1'b1, 1'b0, 1'b0);
            nc_warmup <= (rnd < 5);
            // nc_reset once halfway through
            for (int g = 0; g < gap; g++)
                drive_cycle(1'b0, 1'b0, rnd == ROUNDS / 2 && g == 0);
            drive_cycle(1'b0, 1'b1, 1'b0);
        end
        drive_cycle(1'b0, 1'b0, 1'b0);
        repeat (4) @(posedge clk);
        total = err_v + err_spk + err_vld + dut.u_neuron_asserts.fail_count;
        $display("Errors: v_out %0d, neur_output %0d, spike_valid %0d, assertions %0d",
                 err_v, err_spk, err_vld, dut.u_neuron_asserts.fail_count);
        if (total == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns before the stimulus finished", TIMEOUT_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
